// File: common/valu_pkg.sv
/* Constants, enums and register map of the SIMD vector ALU
   Imported by the RTL modules and by the testbench model */
package valu_pkg;

    ////////////////////////////////////////////////////
    // Vector geometry
    ////////////////////////////////////////////////////
    localparam int VLEN       = 64;
    localparam int LLEN       = 32;
    localparam int LANES      = VLEN / LLEN;
    localparam int VLENB      = VLEN / 8;
    // Elements per lane at SEW8
    localparam int LANE_ELEMS = LLEN / 8;

    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } valu_sew_e;

    typedef enum logic [4:0] {
        VNOP     = 5'd0,
        VADD     = 5'd1,
        VSUB     = 5'd2,
        VAND     = 5'd3,
        VOR      = 5'd4,
        VXOR     = 5'd5,
        VMINU    = 5'd6,
        VMAX     = 5'd7,
        VMUL     = 5'd8,
        VWMULU   = 5'd9,
        VMSEQ    = 5'd10,
        VMSLTU   = 5'd11,
        VREDSUM  = 5'd12,
        VREDMAXU = 5'd13,
        VMV      = 5'd14
    } valu_op_e;

    ////////////////////////////////////////////////////
    // Register map, word address from adr[5:2]
    ////////////////////////////////////////////////////
    localparam logic [3:0] ADDR_OPA_LO   = 4'd0;
    localparam logic [3:0] ADDR_OPA_HI   = 4'd1;
    localparam logic [3:0] ADDR_OPB_LO   = 4'd2;
    localparam logic [3:0] ADDR_OPB_HI   = 4'd3;
    localparam logic [3:0] ADDR_CTRL     = 4'd4;
    localparam logic [3:0] ADDR_RES_MASK = 4'd5;
    localparam logic [3:0] ADDR_RES0     = 4'd6;
    localparam logic [3:0] ADDR_RES1     = 4'd7;
    localparam logic [3:0] ADDR_RES2     = 4'd8;
    localparam logic [3:0] ADDR_RES3     = 4'd9;

    // CTRL field positions
    localparam int CTRL_OP_LSB   = 0;
    localparam int CTRL_SEW_LSB  = 8;
    localparam int CTRL_VM_BIT   = 12;
    localparam int CTRL_MASK_LSB = 16;

endpackage

// File: source/vector_alu/vector_lane.sv
`timescale 1ns/1ps
/* One 32-bit SIMD lane of the vector ALU
   Element-wise arithmetic, compares and widening products, registered on enable */
module vector_lane (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                enable_i,
    input  valu_pkg::valu_op_e                  op_i,
    input  valu_pkg::valu_sew_e                 sew_i,
    input  logic [valu_pkg::LANE_ELEMS-1:0]     active_i,
    input  logic [valu_pkg::LLEN-1:0]           a_i,
    input  logic [valu_pkg::LLEN-1:0]           b_i,
    output logic [valu_pkg::LLEN-1:0]           result_o,
    output logic [2*valu_pkg::LLEN-1:0]         product_o,
    output logic [valu_pkg::LANE_ELEMS-1:0]     cmp_mask_o
);
    import valu_pkg::*;

    logic [LLEN-1:0]       result_d;
    logic [2*LLEN-1:0]     product_d;
    logic [LANE_ELEMS-1:0] cmp_d;

    always_comb begin
        int                ebits;
        int                nel;
        logic [LLEN-1:0]   wmask;
        logic [LLEN-1:0]   sbit;
        logic [LLEN-1:0]   ea;
        logic [LLEN-1:0]   eb;
        logic [LLEN-1:0]   r;
        logic [2*LLEN-1:0] p;

        ebits     = 8 << int'(sew_i);
        nel       = LANE_ELEMS >> int'(sew_i);
        wmask     = LLEN'((64'd1 << ebits) - 64'd1);
        // Sign bit of one element
        sbit      = LLEN'(64'd1 << (ebits - 1));
        ea        = '0;
        eb        = '0;
        r         = '0;
        p         = '0;
        result_d  = '0;
        product_d = '0;
        cmp_d     = '0;
        for (int i = 0; i < LANE_ELEMS; i++) begin
            if (i < nel) begin
                ea = (a_i >> (i * ebits)) & wmask;
                eb = (b_i >> (i * ebits)) & wmask;
                p  = ea * eb;
                case (op_i)
                    VADD:    r = ea + eb;
                    VSUB:    r = ea - eb;
                    VAND:    r = ea & eb;
                    VOR:     r = ea | eb;
                    VXOR:    r = ea ^ eb;
                    VMINU:   r = (ea < eb) ? ea : eb;
                    // Flipping the sign bit turns signed order into unsigned order
                    VMAX:    r = ((ea ^ sbit) > (eb ^ sbit)) ? ea : eb;
                    VMUL:    r = p[LLEN-1:0];
                    default: r = ea;
                endcase
                r = r & wmask;
                if (active_i[i]) begin
                    product_d = product_d | (p << (i * 2 * ebits));
                    cmp_d[i]  = (op_i == VMSEQ && ea == eb) || (op_i == VMSLTU && ea < eb);
                end else begin
                    r = ea;
                end
                result_d = result_d | (r << (i * ebits));
            end
        end
    end

    ////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o   <= '0;
            product_o  <= '0;
            cmp_mask_o <= '0;
        end else if (enable_i) begin
            result_o   <= result_d;
            product_o  <= product_d;
            cmp_mask_o <= cmp_d;
        end
    end

endmodule

// File: source/vector_alu/vector_reductions.sv
`timescale 1ns/1ps
/* Sequential sum and unsigned max reduction of the vector ALU
   Folds the active elements of one lane per cycle into an accumulator */
module vector_reductions (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    input  valu_pkg::valu_op_e              op_i,
    input  valu_pkg::valu_sew_e             sew_i,
    input  logic [valu_pkg::VLENB-1:0]      active_i,
    input  logic [valu_pkg::VLEN-1:0]       vec_i,
    input  logic [valu_pkg::LLEN-1:0]       scalar_i,
    output logic                            valid_o,
    output logic [valu_pkg::LLEN-1:0]       result_o
);
    import valu_pkg::*;

    logic                         busy_q;
    logic [$clog2(LANES)-1:0]     lane_q;
    logic [$clog2(LANES)-1:0]     idx;
    logic [LLEN-1:0]              acc_q;
    logic [LLEN-1:0]              acc_base;
    logic [LLEN-1:0]              lane_data;
    logic [LANE_ELEMS-1:0]        lane_act;

    // Fold one lane into the accumulator at SEW width
    function automatic logic [LLEN-1:0] fold(input logic [LLEN-1:0] acc_in,
                                             input logic [LLEN-1:0] data,
                                             input logic [LANE_ELEMS-1:0] act,
                                             input valu_op_e op, input valu_sew_e sew);
        logic [LLEN-1:0] acc;
        logic [LLEN-1:0] wmask;
        logic [LLEN-1:0] elem;
        int              ebits;

        ebits = 8 << int'(sew);
        wmask = LLEN'((64'd1 << ebits) - 64'd1);
        acc   = acc_in & wmask;
        for (int i = 0; i < LANE_ELEMS; i++) begin
            elem = (data >> (i * ebits)) & wmask;
            if (i < (LANE_ELEMS >> int'(sew)) && act[i]) begin
                if (op == VREDSUM) begin
                    acc = (acc + elem) & wmask;
                end else if (elem > acc) begin
                    acc = elem;
                end
            end
        end
        return acc;
    endfunction

    // Lane 0 and the scalar seed on start, later lanes from the counter
    assign idx       = start_i ? '0 : lane_q;
    assign acc_base  = start_i ? scalar_i : acc_q;
    assign lane_data = vec_i[idx*LLEN +: LLEN];
    assign lane_act  = LANE_ELEMS'(active_i >> (int'(idx) * (LANE_ELEMS >> int'(sew_i))));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q  <= 1'b0;
            valid_o <= 1'b0;
            lane_q  <= '0;
        end else begin
            valid_o <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                lane_q <= $clog2(LANES)'(1);
            end else if (busy_q) begin
                lane_q <= lane_q + 1'b1;
                if (lane_q == $clog2(LANES)'(LANES - 1)) begin
                    busy_q  <= 1'b0;
                    valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i || busy_q) begin
            acc_q <= fold(acc_base, lane_data, lane_act, op_i, sew_i);
        end
    end

    assign result_o = acc_q;

endmodule

// File: source/vector_alu/vector_alu.sv
`timescale 1ns/1ps
/* Vector ALU core with two SIMD lanes and a reduction unit
   Sequences widening beats and selects the result word for the register bank */
module vector_alu (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            start_i,
    input  valu_pkg::valu_op_e              op_i,
    input  valu_pkg::valu_sew_e             sew_i,
    input  logic                            vm_i,
    input  logic [valu_pkg::VLENB-1:0]      mask_i,
    input  logic [valu_pkg::VLEN-1:0]       op_a_i,
    input  logic [valu_pkg::VLEN-1:0]       op_b_i,
    output logic                            result_valid_o,
    output logic                            result_upper_o,
    output logic                            done_o,
    output logic [valu_pkg::VLEN-1:0]       result_o,
    output logic [valu_pkg::VLENB-1:0]      result_mask_o
);
    import valu_pkg::*;

    logic [VLENB-1:0]      active;
    logic [LANE_ELEMS-1:0] lane_active  [LANES];
    logic [LLEN-1:0]       lane_result  [LANES];
    logic [2*LLEN-1:0]     lane_product [LANES];
    logic [LANE_ELEMS-1:0] lane_cmp     [LANES];
    logic [VLEN-1:0]       lanes_flat;
    logic [2*VLEN-1:0]     product_flat;
    logic [VLENB-1:0]      cmp_mask;
    logic [LLEN-1:0]       red_result;
    logic                  red_valid;
    logic                  is_wide;
    logic                  is_red;
    logic                  go;
    logic                  first_q;
    logic                  wide_q;
    logic                  wide_hi_q;
    logic                  red_q;
    valu_op_e              op_q;
    valu_sew_e             sew_q;
    logic [VLEN-1:0]       move_q;

    assign is_wide = (op_i == VWMULU);
    assign is_red  = (op_i inside {VREDSUM, VREDMAXU});
    // No new start while a widening or reduction sequence runs
    assign go      = start_i & ~(wide_q | red_q);

    ////////////////////////////////////////////////////
    // Mask to per-lane active bits
    ////////////////////////////////////////////////////
    always_comb begin
        active = vm_i ? '1 : mask_i;
        for (int l = 0; l < LANES; l++) begin
            lane_active[l] = LANE_ELEMS'(active >> (l * (LANE_ELEMS >> int'(sew_i))));
        end
    end

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        vector_lane u_lane (
            .clk        (clk),
            .reset_n    (reset_n),
            .enable_i   (go & ~is_red),
            .op_i       (op_i),
            .sew_i      (sew_i),
            .active_i   (lane_active[l]),
            .a_i        (op_a_i[l*LLEN +: LLEN]),
            .b_i        (op_b_i[l*LLEN +: LLEN]),
            .result_o   (lane_result[l]),
            .product_o  (lane_product[l]),
            .cmp_mask_o (lane_cmp[l])
        );
        assign lanes_flat[l*LLEN +: LLEN]       = lane_result[l];
        assign product_flat[l*2*LLEN +: 2*LLEN] = lane_product[l];
    end

    vector_reductions u_reductions (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (go & is_red),
        .op_i     (op_i),
        .sew_i    (sew_i),
        .active_i (active),
        .vec_i    (op_a_i),
        .scalar_i (op_b_i[LLEN-1:0]),
        .valid_o  (red_valid),
        .result_o (red_result)
    );

    ////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            first_q   <= 1'b0;
            wide_q    <= 1'b0;
            wide_hi_q <= 1'b0;
            red_q     <= 1'b0;
            op_q      <= VNOP;
            sew_q     <= EW8;
        end else begin
            first_q   <= go & ~is_red;
            wide_q    <= go & is_wide;
            wide_hi_q <= wide_q;
            red_q     <= go & is_red;
            if (go) begin
                op_q  <= op_i;
                sew_q <= sew_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            move_q <= op_b_i;
        end
    end

    assign result_valid_o = first_q | wide_hi_q | red_valid;
    assign result_upper_o = wide_hi_q;
    // Low beat of a widening multiply is not the last one
    assign done_o         = (first_q & ~wide_q) | wide_hi_q | red_valid;

    always_comb begin
        case (op_q)
            VREDSUM, VREDMAXU: result_o = {{(VLEN-LLEN){1'b0}}, red_result};
            VMV:               result_o = move_q;
            VWMULU:            result_o = wide_hi_q ? product_flat[2*VLEN-1:VLEN]
                                                    : product_flat[VLEN-1:0];
            default:           result_o = lanes_flat;
        endcase
    end

    // Gather lane compare bits into element order
    always_comb begin
        int nel;

        nel      = LANE_ELEMS >> int'(sew_q);
        cmp_mask = '0;
        for (int l = 0; l < LANES; l++) begin
            for (int i = 0; i < LANE_ELEMS; i++) begin
                if (i < nel) begin
                    cmp_mask[l*nel + i] = lane_cmp[l][i];
                end
            end
        end
    end

    assign result_mask_o = (op_q inside {VMSEQ, VMSLTU}) ? cmp_mask : '0;

endmodule

// File: source/valu_wb_regs.sv
`timescale 1ns/1ps
/* Wishbone classic register bank of the vector ALU
   A CTRL write starts the core and its ack waits for done */
module valu_wb_regs (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [5:0]                      wb_adr_i,
    input  logic [31:0]                     wb_dat_i,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            start_o,
    output valu_pkg::valu_op_e              op_o,
    output valu_pkg::valu_sew_e             sew_o,
    output logic                            vm_o,
    output logic [valu_pkg::VLENB-1:0]      mask_o,
    output logic [valu_pkg::VLEN-1:0]       op_a_o,
    output logic [valu_pkg::VLEN-1:0]       op_b_o,
    input  logic                            result_valid_i,
    input  logic                            result_upper_i,
    input  logic                            done_i,
    input  logic [valu_pkg::VLEN-1:0]       result_i,
    input  logic [valu_pkg::VLENB-1:0]      result_mask_i
);
    import valu_pkg::*;

    logic [VLEN-1:0]  op_a_q;
    logic [VLEN-1:0]  op_b_q;
    logic [31:0]      ctrl_q;
    logic [31:0]      ctrl_w;
    logic [VLEN-1:0]  res_lo_q;
    logic [VLEN-1:0]  res_hi_q;
    logic [VLENB-1:0] res_mask_q;
    logic [3:0]       word;
    logic             access;
    logic             new_acc;
    logic             ctrl_wr;
    logic             taken_q;
    logic             pending_q;

    assign access  = wb_cyc_i & wb_stb_i;
    // One access per stb assertion
    assign new_acc = access & ~taken_q;
    assign word    = wb_adr_i[5:2];
    assign ctrl_wr = new_acc & wb_we_i & (word == ADDR_CTRL);

    // Control fields straight from the bus in the start cycle
    assign ctrl_w  = ctrl_wr ? wb_dat_i : ctrl_q;
    assign start_o = ctrl_wr;
    assign op_o    = valu_op_e'(ctrl_w[CTRL_OP_LSB +: $bits(valu_op_e)]);
    assign sew_o   = valu_sew_e'(ctrl_w[CTRL_SEW_LSB +: $bits(valu_sew_e)]);
    assign vm_o    = ctrl_w[CTRL_VM_BIT];
    assign mask_o  = ctrl_w[CTRL_MASK_LSB +: VLENB];
    assign op_a_o  = op_a_q;
    assign op_b_o  = op_b_q;

    ////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            taken_q   <= 1'b0;
            pending_q <= 1'b0;
            wb_ack_o  <= 1'b0;
        end else begin
            wb_ack_o <= new_acc & ~ctrl_wr;
            if (new_acc) begin
                taken_q <= 1'b1;
            end else if (!access) begin
                taken_q <= 1'b0;
            end
            if (ctrl_wr) begin
                pending_q <= 1'b1;
            end else if (pending_q && done_i) begin
                pending_q <= 1'b0;
                wb_ack_o  <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (new_acc && wb_we_i) begin
            case (word)
                ADDR_OPA_LO: op_a_q[LLEN-1:0]    <= wb_dat_i;
                ADDR_OPA_HI: op_a_q[VLEN-1:LLEN] <= wb_dat_i;
                ADDR_OPB_LO: op_b_q[LLEN-1:0]    <= wb_dat_i;
                ADDR_OPB_HI: op_b_q[VLEN-1:LLEN] <= wb_dat_i;
                default:     ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q     <= {{(32-$bits(valu_op_e)){1'b0}}, VNOP};
            res_lo_q   <= '0;
            res_hi_q   <= '0;
            res_mask_q <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= wb_dat_i;
            end
            if (result_valid_i && result_upper_i) begin
                res_hi_q <= result_i;
            end else if (result_valid_i) begin
                res_lo_q <= result_i;
            end
            if (done_i) begin
                res_mask_q <= result_mask_i;
            end
        end
    end

    // Read data, held by the master until ack
    always_comb begin
        case (word)
            ADDR_OPA_LO:   wb_dat_o = op_a_q[LLEN-1:0];
            ADDR_OPA_HI:   wb_dat_o = op_a_q[VLEN-1:LLEN];
            ADDR_OPB_LO:   wb_dat_o = op_b_q[LLEN-1:0];
            ADDR_OPB_HI:   wb_dat_o = op_b_q[VLEN-1:LLEN];
            ADDR_CTRL:     wb_dat_o = ctrl_q;
            ADDR_RES_MASK: wb_dat_o = {{(32-VLENB){1'b0}}, res_mask_q};
            ADDR_RES0:     wb_dat_o = res_lo_q[LLEN-1:0];
            ADDR_RES1:     wb_dat_o = res_lo_q[VLEN-1:LLEN];
            ADDR_RES2:     wb_dat_o = res_hi_q[LLEN-1:0];
            ADDR_RES3:     wb_dat_o = res_hi_q[VLEN-1:LLEN];
            default:       wb_dat_o = '0;
        endcase
    end

endmodule

// File: source/valu_top.sv
`timescale 1ns/1ps
/* Top level of the vector ALU with a Wishbone classic slave port */
module valu_top (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [5:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);
    import valu_pkg::*;

    logic             start;
    valu_op_e         op;
    valu_sew_e        sew;
    logic             vm;
    logic [VLENB-1:0] mask;
    logic [VLEN-1:0]  op_a;
    logic [VLEN-1:0]  op_b;
    logic             result_valid;
    logic             result_upper;
    logic             done;
    logic [VLEN-1:0]  result;
    logic [VLENB-1:0] result_mask;

    valu_wb_regs u_regs (
        .clk            (clk),
        .reset_n        (reset_n),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .start_o        (start),
        .op_o           (op),
        .sew_o          (sew),
        .vm_o           (vm),
        .mask_o         (mask),
        .op_a_o         (op_a),
        .op_b_o         (op_b),
        .result_valid_i (result_valid),
        .result_upper_i (result_upper),
        .done_i         (done),
        .result_i       (result),
        .result_mask_i  (result_mask)
    );

    vector_alu u_alu (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start),
        .op_i           (op),
        .sew_i          (sew),
        .vm_i           (vm),
        .mask_i         (mask),
        .op_a_i         (op_a),
        .op_b_i         (op_b),
        .result_valid_o (result_valid),
        .result_upper_o (result_upper),
        .done_o         (done),
        .result_o       (result),
        .result_mask_o  (result_mask)
    );

endmodule

// File: testbench/valu_tb_model.svh
/* Reference model of the vector ALU and the LFSR behind the random stimulus
   Included in the testbench module body after the package import */
`ifndef VALU_TB_MODEL_SVH
`define VALU_TB_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;

    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

// Expected 128-bit result and mask of one operation, element by element
function automatic void ref_model(
    input  valu_op_e          op,
    input  valu_sew_e         sew,
    input  logic              vm,
    input  logic [VLENB-1:0]  mask,
    input  logic [VLEN-1:0]   a,
    input  logic [VLEN-1:0]   b,
    output logic [2*VLEN-1:0] res,
    output logic [VLENB-1:0]  res_mask
);
    int                ebits;
    int                nel;
    logic [63:0]       emask;
    logic [63:0]       ea;
    logic [63:0]       eb;
    logic [63:0]       r;
    logic [63:0]       acc;
    logic [2*VLEN-1:0] wide;
    longint            sa;
    longint            sb;
    logic              act;

    ebits    = 8 << int'(sew);
    nel      = VLENB >> int'(sew);
    emask    = (64'd1 << ebits) - 64'd1;
    res      = '0;
    res_mask = '0;
    wide     = '0;
    // Reductions are seeded with element 0 of b
    acc      = b & emask;
    for (int i = 0; i < nel; i++) begin
        ea  = (a >> (i * ebits)) & emask;
        eb  = (b >> (i * ebits)) & emask;
        sa  = longint'(ea << (64 - ebits)) >>> (64 - ebits);
        sb  = longint'(eb << (64 - ebits)) >>> (64 - ebits);
        act = vm || mask[i];
        case (op)
            VADD:    r = ea + eb;
            VSUB:    r = ea - eb;
            VAND:    r = ea & eb;
            VOR:     r = ea | eb;
            VXOR:    r = ea ^ eb;
            VMINU:   r = (ea < eb) ? ea : eb;
            VMAX:    r = (sa > sb) ? ea : eb;
            VMUL:    r = ea * eb;
            VMV:     r = eb;
            default: r = ea;
        endcase
        // Move copies b whatever the mask
        if (!act && op != VMV) begin
            r = ea;
        end
        res[VLEN-1:0] = res[VLEN-1:0] | ((r & emask) << (i * ebits));
        if (act) begin
            wide        = wide | (128'(ea * eb) << (i * 2 * ebits));
            res_mask[i] = (op == VMSEQ && ea == eb) || (op == VMSLTU && ea < eb);
            if (op == VREDSUM) begin
                acc = (acc + ea) & emask;
            end else if (op == VREDMAXU && ea > acc) begin
                acc = ea;
            end
        end
    end
    if (op == VWMULU) begin
        res = wide;
    end else if (op == VREDSUM || op == VREDMAXU) begin
        res = 128'(acc);
    end
endfunction

`endif

// File: testbench/valu_tb.sv
`timescale 1ns/1ps
/* Testbench of the vector ALU, drives the Wishbone port with random vectors
   and compares every result word and mask with the reference model */
module valu_tb;
    import valu_pkg::*;

    localparam int N_VEC = 40;
    localparam int N_OPS = 14;
    // Up to ten bus accesses per vector, 12 cycles allowed for each
    localparam int N_ACCESSES     = 2 * N_OPS * N_VEC * 10 + 64;
    localparam int TIMEOUT_CYCLES = N_ACCESSES * 12;

    logic        clk;
    logic        reset_n;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [5:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [15:0] lfsr_state;
    int          cycle_count;

    `include "valu_tb_model.svh"

    valu_top valu_top_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout, run not finished after %0d cycles", cycle_count));
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;

        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [LLEN-1:0] got,
                              input logic [LLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input logic [VLENB-1:0] got,
                              input logic [VLENB-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////
    // Ack is sampled on the edge, so it shows the cycle just ended
    task automatic bus_access(input logic we, input logic [3:0] word, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int latency);
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= {word, 2'b00};
        wb_dat_i <= wdata;
        latency = 0;
        @(posedge clk);
        while (!wb_ack_o) begin
            latency++;
            @(posedge clk);
        end
        rdata = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic write_word(input logic [3:0] word, input logic [31:0] data);
        logic [31:0] rd;
        int          lat;

        bus_access(1'b1, word, data, rd, lat);
        if (lat != 1) begin
            report_failure($sformatf("Write to word %0d acked after %0d cycles", word, lat));
        end
    endtask

    task automatic read_word(input logic [3:0] word, output logic [31:0] data);
        int lat;

        bus_access(1'b0, word, '0, data, lat);
        if (lat != 1) begin
            report_failure($sformatf("Read of word %0d acked after %0d cycles", word, lat));
        end
    endtask

    task automatic load_operands(input logic [VLEN-1:0] a, input logic [VLEN-1:0] b);
        write_word(ADDR_OPA_LO, a[LLEN-1:0]);
        write_word(ADDR_OPA_HI, a[VLEN-1:LLEN]);
        write_word(ADDR_OPB_LO, b[LLEN-1:0]);
        write_word(ADDR_OPB_HI, b[VLEN-1:LLEN]);
    endtask

    // Widening and reduction runs hold ack one cycle longer
    task automatic run_op(input valu_op_e op, input valu_sew_e sew, input logic vm,
                          input logic [VLENB-1:0] mask);
        logic [31:0] ctrl;
        logic [31:0] rd;
        int          lat;
        int          exp_lat;

        ctrl                          = '0;
        ctrl[CTRL_OP_LSB +: 5]        = op;
        ctrl[CTRL_SEW_LSB +: 2]       = sew;
        ctrl[CTRL_VM_BIT]             = vm;
        ctrl[CTRL_MASK_LSB +: VLENB]  = mask;
        bus_access(1'b1, ADDR_CTRL, ctrl, rd, lat);
        exp_lat = (op inside {VWMULU, VREDSUM, VREDMAXU}) ? 3 : 2;
        if (lat != exp_lat) begin
            report_failure($sformatf("CTRL write for %s acked after %0d cycles instead of %0d",
                                     op.name(), lat, exp_lat));
        end
    endtask

    task automatic run_vector(input valu_op_e op, input valu_sew_e sew, input logic vm,
                              input logic [VLENB-1:0] mask, input logic [VLEN-1:0] a,
                              input logic [VLEN-1:0] b);
        logic [2*VLEN-1:0] exp_res;
        logic [VLENB-1:0]  exp_mask;
        logic [31:0]       rd;
        string             label;

        label = $sformatf("%s/%s vm=%0b", op.name(), sew.name(), vm);
        ref_model(op, sew, vm, mask, a, b, exp_res, exp_mask);
        load_operands(a, b);
        run_op(op, sew, vm, mask);
        read_word(ADDR_RES0, rd);
        check_data({label, " RES0"}, rd, exp_res[31:0]);
        read_word(ADDR_RES1, rd);
        check_data({label, " RES1"}, rd, exp_res[63:32]);
        if (op == VWMULU) begin
            read_word(ADDR_RES2, rd);
            check_data({label, " RES2"}, rd, exp_res[95:64]);
            read_word(ADDR_RES3, rd);
            check_data({label, " RES3"}, rd, exp_res[127:96]);
        end
        read_word(ADDR_RES_MASK, rd);
        check_mask({label, " RES_MASK"}, rd[VLENB-1:0], exp_mask);
    endtask

    initial begin
        logic [VLEN-1:0]   a;
        logic [VLEN-1:0]   b;
        logic [VLENB-1:0]  mask;
        logic [2*VLEN-1:0] exp_res;
        logic [VLENB-1:0]  exp_mask;
        logic [31:0]       word_val;
        logic [31:0]       rd;
        valu_op_e          op;
        valu_sew_e         sew;

        clk         = 1'b0;
        reset_n     = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        lfsr_state  = 16'd46982;
        cycle_count = 0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        // Reset state of results and control
        for (int w = int'(ADDR_RES0); w <= int'(ADDR_RES3); w++) begin
            read_word(4'(w), rd);
            check_data($sformatf("word %0d after reset", w), rd, '0);
        end
        read_word(ADDR_RES_MASK, rd);
        check_mask("RES_MASK after reset", rd[VLENB-1:0], '0);
        read_word(ADDR_CTRL, rd);
        check_data("CTRL after reset", rd, 32'(VNOP));

        for (int w = int'(ADDR_OPA_LO); w <= int'(ADDR_OPB_HI); w++) begin
            word_val = rand_bits(32);
            write_word(4'(w), word_val);
            read_word(4'(w), rd);
            check_data($sformatf("operand word %0d", w), rd, word_val);
        end

        ////////////////////////////////////////////////////
        // Random vectors, all ops, vm = 1 then masked
        ////////////////////////////////////////////////////
        for (int pass = 0; pass < 2; pass++) begin
            for (int o = 1; o <= N_OPS; o++) begin
                for (int v = 0; v < N_VEC; v++) begin
                    op         = valu_op_e'(o);
                    sew        = valu_sew_e'(v % 3);
                    mask       = VLENB'(rand_bits(VLENB));
                    a[63:32]   = rand_bits(32);
                    a[31:0]    = rand_bits(32);
                    b[63:32]   = rand_bits(32);
                    b[31:0]    = rand_bits(32);
                    // Some equal elements for VMSEQ
                    if (v % 4 == 0) begin
                        b[LLEN-1:0] = a[LLEN-1:0];
                    end
                    run_vector(op, sew, pass == 0, mask, a, b);
                end
            end
        end

        // Operand write straight after a multi-cycle operation
        for (int k = 0; k < 2; k++) begin
            op       = (k == 0) ? VWMULU : VREDMAXU;
            mask     = VLENB'(rand_bits(VLENB));
            a[63:32] = rand_bits(32);
            a[31:0]  = rand_bits(32);
            b[63:32] = rand_bits(32);
            b[31:0]  = rand_bits(32);
            ref_model(op, EW8, 1'b0, mask, a, b, exp_res, exp_mask);
            load_operands(a, b);
            run_op(op, EW8, 1'b0, mask);
            word_val = rand_bits(32);
            write_word(ADDR_OPA_LO, word_val);
            read_word(ADDR_OPA_LO, rd);
            check_data("OPA_LO after CTRL write", rd, word_val);
            read_word(ADDR_RES0, rd);
            check_data({op.name(), " RES0 after operand write"}, rd, exp_res[31:0]);
            read_word(ADDR_RES_MASK, rd);
            check_mask({op.name(), " RES_MASK after operand write"}, rd[VLENB-1:0], exp_mask);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: sim.f
+incdir+testbench
common/valu_pkg.sv
source/vector_alu/vector_lane.sv
source/vector_alu/vector_reductions.sv
source/vector_alu/vector_alu.sv
source/valu_wb_regs.sv
source/valu_top.sv
testbench/valu_tb.sv
